//--- src/floo_lite_pkg.sv
// Shared types and sizes for the five port mesh router
// Port indices follow route_dir_e everywhere, Eject is the local port
// A flit carries its destination coordinates above the payload
`default_nettype none

package floo_lite_pkg;

  // Port order used by every per-port vector in the design
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  localparam int unsigned NumPorts     = 5;
  localparam int unsigned PortSelWidth = 3;

  // Mesh coordinates, one per axis
  localparam int unsigned CoordWidth = 2;
  typedef logic [CoordWidth-1:0] coord_t;

  localparam int unsigned PayloadWidth = 16;
  typedef logic [PayloadWidth-1:0] payload_t;

  // Layout from the top bit down: dst x, dst y, payload
  typedef logic [2*CoordWidth+PayloadWidth-1:0] flit_t;

  // One bit per port, one-hot or empty
  typedef logic [NumPorts-1:0] port_mask_t;

  localparam int unsigned DefaultFifoDepth = 2;

endpackage

`default_nettype wire

//--- src/router_in_port.sv
// Input port: a circular FIFO plus XY route of the head flit
// Ready depends only on the fill level, never on the switch side
// Route is only meaningful while head_valid_o is high
`timescale 1ns/1ps
`default_nettype none

module router_in_port #(
  parameter int unsigned FifoDepth = floo_lite_pkg::DefaultFifoDepth
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  input  floo_lite_pkg::flit_t      data_i,
  input  floo_lite_pkg::coord_t     xy_x_i,
  input  floo_lite_pkg::coord_t     xy_y_i,
  output logic                      head_valid_o,
  output floo_lite_pkg::flit_t      head_flit_o,
  output floo_lite_pkg::port_mask_t head_route_o,
  input  logic                      head_ready_i
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);
  localparam int unsigned DstYLsb  = floo_lite_pkg::PayloadWidth;
  localparam int unsigned DstXLsb  = DstYLsb + floo_lite_pkg::CoordWidth;

  floo_lite_pkg::flit_t  mem_q [FifoDepth];
  logic [PtrWidth-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  push, pop;
  floo_lite_pkg::coord_t dst_x, dst_y;

  // Full FIFO is the only source of back-pressure
  assign ready_o      = (count_q != CntWidth'(FifoDepth));
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = head_valid_o && head_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage only, pointers carry the state
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign dst_x = head_flit_o[DstXLsb +: floo_lite_pkg::CoordWidth];
  assign dst_y = head_flit_o[DstYLsb +: floo_lite_pkg::CoordWidth];

  // Dimension order: resolve X first, then Y, then eject locally
  always_comb begin
    head_route_o = '0;
    if (dst_x > xy_x_i) begin
      head_route_o[floo_lite_pkg::East] = 1'b1;
    end else if (dst_x < xy_x_i) begin
      head_route_o[floo_lite_pkg::West] = 1'b1;
    end else if (dst_y > xy_y_i) begin
      head_route_o[floo_lite_pkg::North] = 1'b1;
    end else if (dst_y < xy_y_i) begin
      head_route_o[floo_lite_pkg::South] = 1'b1;
    end else begin
      head_route_o[floo_lite_pkg::Eject] = 1'b1;
    end
  end

  // Upstream must hold valid and data until the FIFO takes the flit
  a_stable_in: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i && !ready_o |=> valid_i && $stable(data_i))
    else $error("Input dropped valid or changed data while stalled");

  // Write pointer never laps the read pointer
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    (count_q <= CntWidth'(FifoDepth)) &&
    ((wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == CntWidth'(FifoDepth))))
    else $error("Input FIFO overflow or pointer mismatch");

endmodule

`default_nettype wire

//--- src/router_out_arb.sv
// Round-robin arbiter for one output port
// Grant is combinational until a stall, then it is locked until the transfer
// Requests must stay up while granted, which the input FIFOs guarantee
`timescale 1ns/1ps
`default_nettype none

module router_out_arb #(
  parameter int unsigned NumInputs = floo_lite_pkg::NumPorts
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  floo_lite_pkg::port_mask_t req_i,
  input  logic                      ready_i,
  output floo_lite_pkg::port_mask_t gnt_o,
  output logic                      valid_o
);

  localparam int unsigned PtrWidth = floo_lite_pkg::PortSelWidth;

  // Pointer marks the input with highest priority
  logic [PtrWidth-1:0]       ptr_q;
  logic [PtrWidth-1:0]       gnt_idx;
  logic                      lock_q;
  floo_lite_pkg::port_mask_t gnt_q;
  floo_lite_pkg::port_mask_t rr_gnt;

  // Search starts at the pointer and wraps around
  always_comb begin : rr_pick
    int unsigned idx;
    logic        found;
    rr_gnt = '0;
    found  = 1'b0;
    for (int unsigned k = 0; k < NumInputs; k++) begin
      idx = int'(ptr_q) + k;
      if (idx >= NumInputs) begin
        idx = idx - NumInputs;
      end
      if (!found && req_i[idx]) begin
        found       = 1'b1;
        rr_gnt[idx] = 1'b1;
      end
    end
  end

  assign gnt_o   = lock_q ? gnt_q : rr_gnt;
  assign valid_o = |gnt_o;

  // Index of the winner, needed for the pointer update
  always_comb begin : gnt_encode
    gnt_idx = '0;
    for (int unsigned i = 0; i < NumInputs; i++) begin
      if (gnt_o[i]) begin
        gnt_idx = PtrWidth'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
      gnt_q  <= '0;
    end else if (valid_o && ready_i) begin
      // Transfer done, release and rotate past the winner
      lock_q <= 1'b0;
      ptr_q  <= (gnt_idx == PtrWidth'(NumInputs - 1)) ? '0 : gnt_idx + 1'b1;
    end else if (valid_o) begin
      // Stalled, freeze the current winner
      lock_q <= 1'b1;
      gnt_q  <= gnt_o;
    end
  end

  // Grant goes to at most one input, and only to one that requests
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
    else $error("Output grant is not one-hot or targets an idle input");

  // Downstream sees a stable stream while it holds ready low
  a_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(gnt_o) && ((gnt_o & req_i) != '0))
    else $error("Output valid or grant changed while stalled");

endmodule

`default_nettype wire

//--- src/router_switch.sv
// Crossbar between input FIFO heads and the output ports
// One arbiter per output, no path from an input to the output of the same index
// Each input sees ready only from the output that granted it
`timescale 1ns/1ps
`default_nettype none

module router_switch #(
  parameter int unsigned NumInputs  = floo_lite_pkg::NumPorts,
  parameter int unsigned NumOutputs = floo_lite_pkg::NumPorts
) (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic [NumInputs-1:0]                       head_valid_i,
  input  floo_lite_pkg::flit_t [NumInputs-1:0]       head_flit_i,
  input  floo_lite_pkg::port_mask_t [NumInputs-1:0]  head_route_i,
  output logic [NumInputs-1:0]                       head_ready_o,
  output logic [NumOutputs-1:0]                      valid_o,
  input  logic [NumOutputs-1:0]                      ready_i,
  output floo_lite_pkg::flit_t [NumOutputs-1:0]      data_o
);

  // Request and grant, indexed [output][input]
  floo_lite_pkg::port_mask_t [NumOutputs-1:0] req;
  floo_lite_pkg::port_mask_t [NumOutputs-1:0] gnt;

  // Loopback requests are masked off
  always_comb begin
    req = '0;
    for (int unsigned o = 0; o < NumOutputs; o++) begin
      for (int unsigned i = 0; i < NumInputs; i++) begin
        if (i != o) begin
          req[o][i] = head_valid_i[i] && head_route_i[i][o];
        end
      end
    end
  end

  for (genvar o = 0; o < NumOutputs; o++) begin : gen_out
    router_out_arb #(
      .NumInputs ( NumInputs )
    ) u_arb (
      .clk_i   ( clk_i      ),
      .rst_i   ( rst_i      ),
      .req_i   ( req[o]     ),
      .ready_i ( ready_i[o] ),
      .gnt_o   ( gnt[o]     ),
      .valid_o ( valid_o[o] )
    );
  end

  // One-hot grant selects the data, idle outputs drive zero
  always_comb begin
    data_o = '0;
    for (int unsigned o = 0; o < NumOutputs; o++) begin
      for (int unsigned i = 0; i < NumInputs; i++) begin
        if (gnt[o][i]) begin
          data_o[o] = head_flit_i[i];
        end
      end
    end
  end

  // Pop the FIFO head only when its granted output accepts
  always_comb begin
    head_ready_o = '0;
    for (int unsigned o = 0; o < NumOutputs; o++) begin
      for (int unsigned i = 0; i < NumInputs; i++) begin
        if (gnt[o][i] && ready_i[o]) begin
          head_ready_o[i] = 1'b1;
        end
      end
    end
  end

  // A head routed back to its own port would never drain
  for (genvar i = 0; i < NumInputs; i++) begin : gen_loop_chk
    a_no_loopback: assert property (@(posedge clk_i) disable iff (rst_i)
      head_valid_i[i] |-> !head_route_i[i][i])
      else $error("Input %0d routes back to its own port", i);
  end

endmodule

`default_nettype wire

//--- src/floo_router.sv
// Five port XY mesh router node, one flit class, no output buffering
// xy_x_i and xy_y_i must stay constant while traffic flows
// Idle latency is one cycle from input transfer to valid_o
`timescale 1ns/1ps
`default_nettype none

module floo_router #(
  parameter int unsigned InFifoDepth = floo_lite_pkg::DefaultFifoDepth
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  floo_lite_pkg::coord_t xy_x_i,
  input  floo_lite_pkg::coord_t xy_y_i,
  // Input side
  input  logic                  north_valid_i,
  output logic                  north_ready_o,
  input  floo_lite_pkg::flit_t  north_data_i,
  input  logic                  east_valid_i,
  output logic                  east_ready_o,
  input  floo_lite_pkg::flit_t  east_data_i,
  input  logic                  south_valid_i,
  output logic                  south_ready_o,
  input  floo_lite_pkg::flit_t  south_data_i,
  input  logic                  west_valid_i,
  output logic                  west_ready_o,
  input  floo_lite_pkg::flit_t  west_data_i,
  input  logic                  eject_valid_i,
  output logic                  eject_ready_o,
  input  floo_lite_pkg::flit_t  eject_data_i,
  // Output side
  output logic                  north_valid_o,
  input  logic                  north_ready_i,
  output floo_lite_pkg::flit_t  north_data_o,
  output logic                  east_valid_o,
  input  logic                  east_ready_i,
  output floo_lite_pkg::flit_t  east_data_o,
  output logic                  south_valid_o,
  input  logic                  south_ready_i,
  output floo_lite_pkg::flit_t  south_data_o,
  output logic                  west_valid_o,
  input  logic                  west_ready_i,
  output floo_lite_pkg::flit_t  west_data_o,
  output logic                  eject_valid_o,
  input  logic                  eject_ready_i,
  output floo_lite_pkg::flit_t  eject_data_o
);

  localparam int unsigned NumPorts = floo_lite_pkg::NumPorts;

  logic [NumPorts-1:0]                      in_valid, in_ready;
  floo_lite_pkg::flit_t [NumPorts-1:0]      in_data;
  logic [NumPorts-1:0]                      head_valid, head_ready;
  floo_lite_pkg::flit_t [NumPorts-1:0]      head_flit;
  floo_lite_pkg::port_mask_t [NumPorts-1:0] head_route;
  logic [NumPorts-1:0]                      out_valid, out_ready;
  floo_lite_pkg::flit_t [NumPorts-1:0]      out_data;

  // Concatenation order matches route_dir_e, North at bit 0
  assign in_valid = {eject_valid_i, west_valid_i, south_valid_i, east_valid_i, north_valid_i};
  assign in_data  = {eject_data_i, west_data_i, south_data_i, east_data_i, north_data_i};
  assign {eject_ready_o, west_ready_o, south_ready_o, east_ready_o, north_ready_o} = in_ready;

  assign out_ready = {eject_ready_i, west_ready_i, south_ready_i, east_ready_i, north_ready_i};
  assign {eject_valid_o, west_valid_o, south_valid_o, east_valid_o, north_valid_o} = out_valid;
  assign {eject_data_o, west_data_o, south_data_o, east_data_o, north_data_o} = out_data;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_in_port
    router_in_port #(
      .FifoDepth ( InFifoDepth )
    ) u_in_port (
      .clk_i        ( clk_i         ),
      .rst_i        ( rst_i         ),
      .valid_i      ( in_valid[p]   ),
      .ready_o      ( in_ready[p]   ),
      .data_i       ( in_data[p]    ),
      .xy_x_i       ( xy_x_i        ),
      .xy_y_i       ( xy_y_i        ),
      .head_valid_o ( head_valid[p] ),
      .head_flit_o  ( head_flit[p]  ),
      .head_route_o ( head_route[p] ),
      .head_ready_i ( head_ready[p] )
    );
  end

  router_switch #(
    .NumInputs  ( NumPorts ),
    .NumOutputs ( NumPorts )
  ) u_switch (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .head_valid_i ( head_valid ),
    .head_flit_i  ( head_flit  ),
    .head_route_i ( head_route ),
    .head_ready_o ( head_ready ),
    .valid_o      ( out_valid  ),
    .ready_i      ( out_ready  ),
    .data_o       ( out_data   )
  );

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
// Testbench clock and reset source
// Reset is released on a falling edge so it never races the sampling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
// Scoreboard for the router, predicts each output with the XY rule
// One queue per input/output pair, plus the route order of each input FIFO
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  floo_lite_pkg::coord_t               xy_x_i,
  input  floo_lite_pkg::coord_t               xy_y_i,
  input  logic [4:0]                          in_valid_i,
  input  logic [4:0]                          in_ready_i,
  input  floo_lite_pkg::flit_t [4:0]          in_data_i,
  input  logic [4:0]                          out_valid_i,
  input  logic [4:0]                          out_ready_i,
  input  floo_lite_pkg::flit_t [4:0]          out_data_i,
  output int                                  done_o,
  output int                                  passed_o,
  output int                                  errors_o,
  output int                                  pending_o
);

  localparam int N = floo_lite_pkg::NumPorts;

  floo_lite_pkg::flit_t exp_q [N*N][$];
  int                   cyc_q [N*N][$];
  // Output of every flit still inside each input FIFO, oldest first
  int                   head_q [N][$];
  int                   skips [N];
  int                   cycle;
  logic                 after_rst;
  logic [N-1:0]         stall_q;
  floo_lite_pkg::flit_t data_q [N];

  function automatic int predict_out(floo_lite_pkg::flit_t f);
    floo_lite_pkg::coord_t dx, dy;
    dx = f[19:18];
    dy = f[17:16];
    if (dx > xy_x_i) return int'(floo_lite_pkg::East);
    if (dx < xy_x_i) return int'(floo_lite_pkg::West);
    if (dy > xy_y_i) return int'(floo_lite_pkg::North);
    if (dy < xy_y_i) return int'(floo_lite_pkg::South);
    return int'(floo_lite_pkg::Eject);
  endfunction

  initial begin
    done_o    = 0;
    passed_o  = 0;
    errors_o  = 0;
    pending_o = 0;
    for (int j = 0; j < N; j++) skips[j] = 0;
  end

  always @(posedge clk_i) begin : watch
    int src, key, o, t0;
    logic ok;
    floo_lite_pkg::flit_t exp_flit;
    if (rst_i) begin
      cycle     = 0;
      after_rst = 1'b1;
      stall_q   = '0;
    end else begin
      cycle++;
      if (after_rst) begin
        for (int p = 0; p < N; p++) begin
          if (out_valid_i[p] !== 1'b0) begin
            errors_o++;
            $display("ERR %0t valid_o[%0d] expected 0 actual %b", $time, p, out_valid_i[p]);
          end
          if (in_ready_i[p] !== 1'b1) begin
            errors_o++;
            $display("ERR %0t ready_o[%0d] expected 1 actual %b", $time, p, in_ready_i[p]);
          end
        end
        after_rst = 1'b0;
      end
      for (int q = 0; q < N; q++) begin
        // A stalled output must hold valid and data
        if (stall_q[q] && out_valid_i[q] !== 1'b1) begin
          errors_o++;
          $display("ERR %0t valid_o[%0d] expected 1 actual %b", $time, q, out_valid_i[q]);
        end else if (stall_q[q] && out_data_i[q] !== data_q[q]) begin
          errors_o++;
          $display("ERR %0t data_o[%0d] expected %h actual %h",
                   $time, q, data_q[q], out_data_i[q]);
        end
        stall_q[q] = out_valid_i[q] && !out_ready_i[q];
        data_q[q]  = out_data_i[q];
        if (out_valid_i[q] && out_ready_i[q]) begin
          src = int'(out_data_i[q][14:12]);
          key = src * N + q;
          if (src >= N || exp_q[key].size() == 0) begin
            errors_o++;
            $display("Output %0d delivered flit %h that no input sent to it", q, out_data_i[q]);
          end else begin
            ok       = 1'b1;
            exp_flit = exp_q[key].pop_front();
            t0       = cyc_q[key].pop_front();
            pending_o--;
            if (out_data_i[q] !== exp_flit) begin
              ok = 1'b0;
              $display("ERR %0t data_o[%0d] expected %h actual %h",
                       $time, q, exp_flit, out_data_i[q]);
            end
            if (exp_flit[15] && (cycle - t0) != 1) begin
              ok = 1'b0;
              $display("ERR %0t latency[%0d] expected 1 actual %0d", $time, q, cycle - t0);
            end
            // Inputs whose head waits for this output lost one round
            for (int j = 0; j < N; j++) begin
              if (j != src && head_q[j].size() != 0 && head_q[j][0] == q) begin
                skips[j]++;
                if (skips[j] > N - 1) begin
                  ok = 1'b0;
                  $display("Input %0d was passed over %0d times in a row on output %0d",
                           j, skips[j], q);
                end
              end
            end
            skips[src] = 0;
            void'(head_q[src].pop_front());
            if (!ok) errors_o++;
            done_o++;
            if (ok) passed_o++;
            $display("Test %0d: input %0d to output %0d %s",
                     exp_flit[11:7], src, q, ok ? "ok" : "failed");
          end
        end
      end
      for (int p = 0; p < N; p++) begin
        if (in_valid_i[p] && in_ready_i[p]) begin
          o   = predict_out(in_data_i[p]);
          key = p * N + o;
          exp_q[key].push_back(in_data_i[p]);
          cyc_q[key].push_back(cycle);
          head_q[p].push_back(o);
          pending_o++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_floo_router.sv
// Top of the router testbench, node sits at (1,1)
// Payload layout {idle, src port, test id, 7 random bits} lets the checker match flits
// Idle entries run alone with every ready_i high to measure latency
`timescale 1ns/1ps
`default_nettype none

module tb_floo_router;

  localparam int unsigned NumPorts    = floo_lite_pkg::NumPorts;
  localparam int unsigned NumTests    = 20;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned CycleLimit  = NumTests * 4 * NumPorts + ResetCycles;

  logic clk, rst;
  logic [NumPorts-1:0] in_valid, in_ready, out_valid, out_ready, accepted;
  floo_lite_pkg::flit_t [NumPorts-1:0] in_data, out_data;
  floo_lite_pkg::flit_t port_q [NumPorts][$];
  // Columns: idle, input port, dst x, dst y
  logic [7:0]  stim [NumTests];
  logic [31:0] lfsr;
  logic        quiet;
  int          done_cnt, pass_cnt, err_cnt, pending, cycles;

  tb_clk_gen #(.PeriodNs(100), .ResetCycles(ResetCycles)) u_clk (.clk_o(clk), .rst_o(rst));

  floo_router #(.InFifoDepth(floo_lite_pkg::DefaultFifoDepth)) u_dut (
    .clk_i(clk), .rst_i(rst), .xy_x_i(2'd1), .xy_y_i(2'd1),
    .north_valid_i(in_valid[0]), .north_ready_o(in_ready[0]), .north_data_i(in_data[0]),
    .east_valid_i(in_valid[1]), .east_ready_o(in_ready[1]), .east_data_i(in_data[1]),
    .south_valid_i(in_valid[2]), .south_ready_o(in_ready[2]), .south_data_i(in_data[2]),
    .west_valid_i(in_valid[3]), .west_ready_o(in_ready[3]), .west_data_i(in_data[3]),
    .eject_valid_i(in_valid[4]), .eject_ready_o(in_ready[4]), .eject_data_i(in_data[4]),
    .north_valid_o(out_valid[0]), .north_ready_i(out_ready[0]), .north_data_o(out_data[0]),
    .east_valid_o(out_valid[1]), .east_ready_i(out_ready[1]), .east_data_o(out_data[1]),
    .south_valid_o(out_valid[2]), .south_ready_i(out_ready[2]), .south_data_o(out_data[2]),
    .west_valid_o(out_valid[3]), .west_ready_i(out_ready[3]), .west_data_o(out_data[3]),
    .eject_valid_o(out_valid[4]), .eject_ready_i(out_ready[4]), .eject_data_o(out_data[4])
  );

  tb_checker u_chk (
    .clk_i(clk), .rst_i(rst), .xy_x_i(2'd1), .xy_y_i(2'd1),
    .in_valid_i(in_valid), .in_ready_i(in_ready), .in_data_i(in_data),
    .out_valid_i(out_valid), .out_ready_i(out_ready), .out_data_i(out_data),
    .done_o(done_cnt), .passed_o(pass_cnt), .errors_o(err_cnt), .pending_o(pending)
  );

  // Galois LFSR, one step per bit taken
  function logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic wait_idle();
    int busy;
    busy = 1;
    while (busy != 0) begin
      @(negedge clk);
      busy = (|in_valid) || (pending != 0);
      for (int p = 0; p < NumPorts; p++) begin
        if (port_q[p].size() != 0) busy = 1;
      end
    end
  endtask

  always @(posedge clk) accepted <= in_valid & in_ready;

  // Per-port drivers and random back-pressure, all on the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (in_valid[p] && accepted[p]) in_valid[p] = 1'b0;
        if (!in_valid[p] && port_q[p].size() != 0) begin
          in_data[p]  = port_q[p].pop_front();
          in_valid[p] = 1'b1;
        end
        out_ready[p] = quiet || (take_bits(2) != 16'd0);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: traffic did not drain within %0d cycles", CycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [6:0] rnd [NumTests];
    in_valid  = '0;
    in_data   = '0;
    out_ready = '1;
    accepted  = '0;
    quiet     = 1'b0;
    cycles    = 0;
    lfsr      = 32'h43db_6f23;
    // Random payload bits for every entry, drawn before any traffic
    for (int t = 0; t < NumTests; t++) begin
      rnd[t] = 7'(take_bits(7));
    end
    // Idle latency, one entry per output direction
    stim[0]  = {1'b1, 3'd0, 2'd2, 2'd1};
    stim[1]  = {1'b1, 3'd2, 2'd0, 2'd1};
    stim[2]  = {1'b1, 3'd1, 2'd1, 2'd2};
    stim[3]  = {1'b1, 3'd3, 2'd1, 2'd0};
    stim[4]  = {1'b1, 3'd0, 2'd1, 2'd1};
    // Ordered stream West to East
    stim[5]  = {1'b0, 3'd3, 2'd2, 2'd0};
    stim[6]  = {1'b0, 3'd3, 2'd3, 2'd3};
    stim[7]  = {1'b0, 3'd3, 2'd2, 2'd2};
    // North and East compete for South
    // North sends five flits so a starved East shows up
    stim[8]  = {1'b0, 3'd0, 2'd1, 2'd0};
    stim[9]  = {1'b0, 3'd1, 2'd1, 2'd0};
    stim[10] = {1'b0, 3'd0, 2'd1, 2'd0};
    stim[11] = {1'b0, 3'd1, 2'd1, 2'd0};
    stim[12] = {1'b0, 3'd0, 2'd1, 2'd0};
    stim[13] = {1'b0, 3'd1, 2'd1, 2'd0};
    stim[14] = {1'b0, 3'd0, 2'd1, 2'd0};
    stim[15] = {1'b0, 3'd0, 2'd1, 2'd0};
    // Mixed traffic
    stim[16] = {1'b0, 3'd1, 2'd1, 2'd1};
    stim[17] = {1'b0, 3'd3, 2'd1, 2'd2};
    stim[18] = {1'b0, 3'd4, 2'd3, 2'd0};
    stim[19] = {1'b0, 3'd2, 2'd1, 2'd1};
    @(negedge clk);
    while (rst) @(negedge clk);
    for (int t = 0; t < NumTests; t++) begin
      if (stim[t][7]) begin
        wait_idle();
        quiet = 1'b1;
      end
      port_q[stim[t][6:4]].push_back({stim[t][3:0], stim[t][7], stim[t][6:4], 5'(t), rnd[t]});
      if (stim[t][7]) begin
        wait_idle();
        quiet = 1'b0;
      end
    end
    while (done_cnt < NumTests) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("Tests: %0d run, %0d passed, %0d errors", done_cnt, pass_cnt, err_cnt);
    if (err_cnt == 0 && pass_cnt == NumTests) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- floo_router.f
src/floo_lite_pkg.sv
src/router_in_port.sv
src/router_out_arb.sv
src/router_switch.sv
src/floo_router.sv
sim/tb_clk_gen.sv
sim/tb_checker.sv
sim/tb_floo_router.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1

out="$(verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_floo_router -f floo_router.f -o tb_sim 2>&1 \
  && ./obj_dir/tb_sim 2>&1)"
echo "$out"

echo "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
